// File: lsu_core.f
+incdir+common
common/lsu_pkg.sv
common/agu_if.sv
hw/agu.sv
hw/load_rs.sv
store_queue/store_queue.sv
hw/lsu_core_top.sv
bench/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= lsu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/lsu_tb.sv
`default_nettype none

`include "lsu_defines.svh"

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Six tests at up to 200 cycles each
    localparam int TIMEOUT_CYCLES = 6 * 200;

    typedef struct packed {
        lsu_pkg::word_t addr;
        lsu_pkg::word_t data;
    } store_rec_t;

    logic               clk = 1'b0;
    logic               rst;
    logic               flush;
    logic               cdb_valid;
    lsu_pkg::tag_t      cdb_tag;
    lsu_pkg::word_t     cdb_data;
    logic               ld_valid;
    logic               ld_ready;
    lsu_pkg::load_op_t  ld_op;
    logic               st_valid;
    logic               st_ready;
    lsu_pkg::store_op_t st_op;
    logic               st_commit;
    logic               mem_rd_valid;
    logic               mem_rd_ready;
    lsu_pkg::word_t     mem_rd_addr;
    logic               mem_rsp_valid = 1'b0;
    lsu_pkg::word_t     mem_rsp_data = '0;
    logic               mem_wr_valid;
    logic               mem_wr_ready;
    lsu_pkg::word_t     mem_wr_addr;
    lsu_pkg::word_t     mem_wr_data;
    logic               wb_valid;
    logic               wb_ready;
    lsu_pkg::tag_t      wb_tag;
    lsu_pkg::word_t     wb_data;
    logic               wb_forwarded;

    lsu_pkg::word_t mem_model [lsu_pkg::word_t];
    store_rec_t     pending_stores [$];
    int             older_count = 0;
    integer         seed = 32'h1432;
    int             cycle_count = 0;
    int             rd_count = 0;
    int             errors = 0;
    int             test_errors_base = 0;
    int             tests_passed = 0;
    int             tests_failed = 0;
    logic           rd_pending = 1'b0;
    int             rd_delay = 0;
    lsu_pkg::word_t rd_addr = '0;

    lsu_core_top i_dut (.*);

    always #4 clk = ~clk;

    function automatic lsu_pkg::word_t mem_value(lsu_pkg::word_t addr);
        if (mem_model.exists(addr)) begin
            return mem_model[addr];
        end
        return addr ^ 32'hA5A5_A5A5;
    endfunction

    // Memory model answering a read 1 to 3 cycles after it is taken
    always @(posedge clk) begin
        mem_rsp_valid <= 1'b0;
        if (mem_wr_valid && mem_wr_ready) begin
            mem_model[mem_wr_addr] = mem_wr_data;
        end
        if (mem_rd_valid && mem_rd_ready) begin
            rd_pending = 1'b1;
            rd_addr    = mem_rd_addr;
            rd_delay   = 1 + int'($unsigned($random(seed)) % 3);
            rd_count   = rd_count + 1;
        end
        if (rd_pending) begin
            rd_delay = rd_delay - 1;
            if (rd_delay == 0) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= mem_value(rd_addr);
                rd_pending = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_word(string name, lsu_pkg::word_t expected, lsu_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_tag(string name, lsu_pkg::tag_t expected, lsu_pkg::tag_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_error(string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        errors++;
    endtask

    function automatic lsu_pkg::operand_t make_operand(lsu_pkg::tag_t tag, logic ready,
                                                       lsu_pkg::word_t value);
        return lsu_pkg::operand_t'{tag: tag, ready: ready, value: value};
    endfunction

    // Youngest store dispatched before the load wins, else memory
    function automatic lsu_pkg::word_t expected_load(lsu_pkg::word_t addr, int older);
        for (int i = older - 1; i >= 0; i--) begin
            if (pending_stores[i].addr == addr) begin
                return pending_stores[i].data;
            end
        end
        return mem_value(addr);
    endfunction

    task automatic send_load(lsu_pkg::tag_t dest, lsu_pkg::operand_t base,
                             lsu_pkg::word_t offset);
        @(posedge clk);
        ld_valid <= 1'b1;
        ld_op    <= '{dest: dest, base: base, offset: offset};
        older_count = pending_stores.size();
        do @(posedge clk); while (!ld_ready);
        ld_valid <= 1'b0;
    endtask

    task automatic send_store(lsu_pkg::operand_t base, lsu_pkg::operand_t data,
                              lsu_pkg::word_t offset, lsu_pkg::word_t final_data);
        @(posedge clk);
        st_valid <= 1'b1;
        st_op    <= '{base: base, data: data, offset: offset};
        pending_stores.push_back(store_rec_t'{addr: base.value + offset, data: final_data});
        do @(posedge clk); while (!st_ready);
        st_valid <= 1'b0;
    endtask

    task automatic broadcast(lsu_pkg::tag_t tag, lsu_pkg::word_t value);
        @(posedge clk);
        cdb_valid <= 1'b1;
        cdb_tag   <= tag;
        cdb_data  <= value;
        @(posedge clk);
        cdb_valid <= 1'b0;
    endtask

    task automatic check_load(lsu_pkg::tag_t dest, lsu_pkg::word_t addr, logic exp_fwd);
        do @(posedge clk); while (!(wb_valid && wb_ready));
        check_tag("wb_tag", dest, wb_tag);
        check_word("wb_data", expected_load(addr, older_count), wb_data);
        check_flag("wb_forwarded", exp_fwd, wb_forwarded);
        if (!exp_fwd) begin
            check_word("mem_rd_addr", addr, rd_addr);
        end
    endtask

    // Retire the head store and check the write that leaves the queue
    task automatic commit_head();
        store_rec_t rec;
        rec = pending_stores.pop_front();
        @(posedge clk);
        st_commit <= 1'b1;
        @(posedge clk);
        st_commit <= 1'b0;
        do @(posedge clk); while (!(mem_wr_valid && mem_wr_ready));
        check_word("mem_wr_addr", rec.addr, mem_wr_addr);
        check_word("mem_wr_data", rec.data, mem_wr_data);
    endtask

    task automatic drain_stores();
        while (pending_stores.size() > 0) begin
            commit_head();
        end
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        pending_stores.delete();
    endtask

    task automatic begin_test();
        test_errors_base = errors;
    endtask

    task automatic end_test(string name);
        if (errors == test_errors_base) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: %0d error(s)", name, errors - test_errors_base);
        end
    endtask

    task automatic load_from_memory();
        begin_test();
        check_flag("wb_valid", 1'b0, wb_valid);
        check_flag("mem_rd_valid", 1'b0, mem_rd_valid);
        check_flag("mem_wr_valid", 1'b0, mem_wr_valid);
        check_flag("ld_ready", 1'b1, ld_ready);
        check_flag("st_ready", 1'b1, st_ready);
        send_load(6'd5, make_operand(6'd0, 1'b1, 32'h0000_1000), 32'h20);
        check_load(6'd5, 32'h0000_1020, 1'b0);
        end_test("load_from_memory");
    endtask

    task automatic base_from_cdb();
        begin_test();
        send_load(6'd6, make_operand(6'd12, 1'b0, '0), 32'h8);
        broadcast(6'd12, 32'h0000_2000);
        check_load(6'd6, 32'h0000_2008, 1'b0);
        end_test("base_from_cdb");
    endtask

    task automatic forward_from_store();
        int rd_before;
        begin_test();
        rd_before = rd_count;
        send_store(make_operand(6'd1, 1'b1, 32'h0000_3000),
                   make_operand(6'd2, 1'b1, 32'hDEAD_BEEF), 32'h4, 32'hDEAD_BEEF);
        send_load(6'd7, make_operand(6'd3, 1'b1, 32'h0000_3000), 32'h4);
        check_load(6'd7, 32'h0000_3004, 1'b1);
        if (rd_count != rd_before) begin
            report_error("a memory read was issued for a load that should forward");
        end
        drain_stores();
        end_test("store_forward");
    endtask

    task automatic pick_youngest_store();
        begin_test();
        send_store(make_operand(6'd0, 1'b1, 32'h0000_4000),
                   make_operand(6'd0, 1'b1, 32'h1111_1111), 32'h0, 32'h1111_1111);
        send_store(make_operand(6'd0, 1'b1, 32'h0000_3FF0),
                   make_operand(6'd0, 1'b1, 32'h2222_2222), 32'h10, 32'h2222_2222);
        send_load(6'd8, make_operand(6'd0, 1'b1, 32'h0000_4000), 32'h0);
        check_load(6'd8, 32'h0000_4000, 1'b1);
        // Store after the load hits the same address and must be skipped
        send_load(6'd9, make_operand(6'd20, 1'b0, '0), 32'h0);
        send_store(make_operand(6'd0, 1'b1, 32'h0000_5000),
                   make_operand(6'd0, 1'b1, 32'h3333_3333), 32'h0, 32'h3333_3333);
        broadcast(6'd20, 32'h0000_5000);
        check_load(6'd9, 32'h0000_5000, 1'b0);
        drain_stores();
        end_test("youngest_older_store");
    endtask

    task automatic stall_on_store_data();
        begin_test();
        send_store(make_operand(6'd0, 1'b1, 32'h0000_6000),
                   make_operand(6'd30, 1'b0, '0), 32'hC, 32'h5A5A_0F0F);
        send_load(6'd11, make_operand(6'd0, 1'b1, 32'h0000_6000), 32'hC);
        repeat (8) begin
            @(posedge clk);
            if (wb_valid || mem_rd_valid) begin
                report_error("load went ahead before the older store data was known");
            end
        end
        broadcast(6'd30, 32'h5A5A_0F0F);
        check_load(6'd11, 32'h0000_600C, 1'b1);
        commit_head();
        send_load(6'd12, make_operand(6'd0, 1'b1, 32'h0000_6000), 32'hC);
        check_load(6'd12, 32'h0000_600C, 1'b0);
        end_test("pending_store_data");
    endtask

    task automatic backpressure_and_flush();
        lsu_pkg::tag_t  held_tag;
        lsu_pkg::word_t held_data;
        begin_test();
        wb_ready <= 1'b0;
        send_load(6'd13, make_operand(6'd0, 1'b1, 32'h0000_7000), 32'h10);
        do @(posedge clk); while (!wb_valid);
        held_tag  = wb_tag;
        held_data = wb_data;
        repeat (5) begin
            @(posedge clk);
            check_flag("wb_valid", 1'b1, wb_valid);
            check_tag("wb_tag", held_tag, wb_tag);
            check_word("wb_data", held_data, wb_data);
        end
        wb_ready <= 1'b1;
        check_load(6'd13, 32'h0000_7010, 1'b0);
        // Full queue of stores and a load, all waiting on tags
        for (int i = 0; i < `LSU_STQ_DEPTH; i++) begin
            send_store(make_operand(6'd40, 1'b0, 32'h0000_8000),
                       make_operand(6'd0, 1'b1, 32'hCAFE_0000 + i), 32'h0,
                       32'hCAFE_0000 + i);
        end
        send_load(6'd15, make_operand(6'd41, 1'b0, '0), 32'h0);
        @(posedge clk);
        check_flag("st_ready", 1'b0, st_ready);
        check_flag("ld_ready", 1'b0, ld_ready);
        pulse_flush();
        @(posedge clk);
        check_flag("st_ready", 1'b1, st_ready);
        check_flag("ld_ready", 1'b1, ld_ready);
        send_load(6'd14, make_operand(6'd0, 1'b1, 32'h0000_8000), 32'h0);
        check_load(6'd14, 32'h0000_8000, 1'b0);
        end_test("backpressure_and_flush");
    endtask

    initial begin
        rst          = 1'b1;
        flush        = 1'b0;
        cdb_valid    = 1'b0;
        cdb_tag      = '0;
        cdb_data     = '0;
        ld_valid     = 1'b0;
        ld_op        = '0;
        st_valid     = 1'b0;
        st_op        = '0;
        st_commit    = 1'b0;
        mem_rd_ready = 1'b1;
        mem_wr_ready = 1'b1;
        wb_ready     = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        load_from_memory();
        base_from_cdb();
        forward_from_store();
        pick_youngest_store();
        stall_on_store_data();
        backpressure_and_flush();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/lsu_core_top.sv
`default_nettype none

`include "lsu_defines.svh"

module lsu_core_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               cdb_valid,
    input  lsu_pkg::tag_t      cdb_tag,
    input  lsu_pkg::word_t     cdb_data,
    input  logic               ld_valid,
    output logic               ld_ready,
    input  lsu_pkg::load_op_t  ld_op,
    input  logic               st_valid,
    output logic               st_ready,
    input  lsu_pkg::store_op_t st_op,
    input  logic               st_commit,
    output logic               mem_rd_valid,
    input  logic               mem_rd_ready,
    output lsu_pkg::word_t     mem_rd_addr,
    input  logic               mem_rsp_valid,
    input  lsu_pkg::word_t     mem_rsp_data,
    output logic               mem_wr_valid,
    input  logic               mem_wr_ready,
    output lsu_pkg::word_t     mem_wr_addr,
    output lsu_pkg::word_t     mem_wr_data,
    output logic               wb_valid,
    input  logic               wb_ready,
    output lsu_pkg::tag_t      wb_tag,
    output lsu_pkg::word_t     wb_data,
    output logic               wb_forwarded
);

    lsu_pkg::cdb_packet_t cdb;
    lsu_pkg::stq_entry_t  stq_entries [`LSU_STQ_DEPTH];
    lsu_pkg::stq_idx_t    stq_head;
    lsu_pkg::stq_mask_t   stq_occupied;

    assign cdb = '{valid: cdb_valid, tag: cdb_tag, value: cdb_data};

    // Loads tag requests by destination register, stores by slot
    agu_if #(.payload_t(lsu_pkg::tag_t))    ld_agu_bus ();
    agu_if #(.payload_t(lsu_pkg::stq_idx_t)) st_agu_bus ();

    agu #(.payload_t(lsu_pkg::tag_t)) i_ld_agu (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .port  (ld_agu_bus)
    );

    agu #(.payload_t(lsu_pkg::stq_idx_t)) i_st_agu (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .port  (st_agu_bus)
    );

    store_queue i_store_queue (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .cdb          (cdb),
        .st_valid     (st_valid),
        .st_ready     (st_ready),
        .st_op        (st_op),
        .agu          (st_agu_bus),
        .st_commit    (st_commit),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_ready (mem_wr_ready),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .entries      (stq_entries),
        .head         (stq_head),
        .occupied     (stq_occupied)
    );

    load_rs i_load_rs (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .cdb           (cdb),
        .ld_valid      (ld_valid),
        .ld_ready      (ld_ready),
        .ld_op         (ld_op),
        .stq_entries   (stq_entries),
        .stq_head      (stq_head),
        .stq_occupied  (stq_occupied),
        .agu           (ld_agu_bus),
        .mem_rd_valid  (mem_rd_valid),
        .mem_rd_ready  (mem_rd_ready),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .wb_valid      (wb_valid),
        .wb_ready      (wb_ready),
        .wb_tag        (wb_tag),
        .wb_data       (wb_data),
        .wb_forwarded  (wb_forwarded)
    );

endmodule

`default_nettype wire

// File: store_queue/store_queue.sv
`default_nettype none

`include "lsu_defines.svh"

module store_queue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  lsu_pkg::cdb_packet_t cdb,
    input  logic                 st_valid,
    output logic                 st_ready,
    input  lsu_pkg::store_op_t   st_op,
    agu_if.requester             agu,
    input  logic                 st_commit,
    output logic                 mem_wr_valid,
    input  logic                 mem_wr_ready,
    output lsu_pkg::word_t       mem_wr_addr,
    output lsu_pkg::word_t       mem_wr_data,
    output lsu_pkg::stq_entry_t  entries [`LSU_STQ_DEPTH],
    output lsu_pkg::stq_idx_t    head,
    output lsu_pkg::stq_mask_t   occupied
);

    localparam int DEPTH = `LSU_STQ_DEPTH;

    lsu_pkg::stq_entry_t entries_q [DEPTH];
    lsu_pkg::operand_t   base_q [DEPTH];
    lsu_pkg::word_t      offset_q [DEPTH];
    lsu_pkg::stq_mask_t  requested_q;
    lsu_pkg::stq_idx_t   head_q;
    lsu_pkg::stq_idx_t   tail_q;
    logic                req_valid_q;
    lsu_pkg::stq_idx_t   req_idx_q;
    logic                wr_valid_q;

    logic              alloc;
    logic              wr_done;
    logic              head_ready;
    logic              pick_load;
    logic              pick_found;
    lsu_pkg::stq_idx_t pick_idx;
    lsu_pkg::stq_idx_t scan_idx;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            occupied[i] = entries_q[i].valid;
        end
    end

    assign entries  = entries_q;
    assign head     = head_q;
    assign st_ready = !(&occupied);
    assign alloc    = st_valid && st_ready;
    assign wr_done  = wr_valid_q && mem_wr_ready;

    assign head_ready = entries_q[head_q].valid && entries_q[head_q].addr_valid
                        && entries_q[head_q].data.ready;

    // Oldest slot with its base known and no address asked for yet
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = '0;
        scan_idx   = head_q;
        for (int k = 0; k < DEPTH; k++) begin
            if (!pick_found && entries_q[scan_idx].valid && base_q[scan_idx].ready
                && !entries_q[scan_idx].addr_valid && !requested_q[scan_idx]) begin
                pick_found = 1'b1;
                pick_idx   = scan_idx;
            end
            scan_idx = scan_idx + 1'b1;
        end
    end

    // Request register refills once the current request is taken
    assign pick_load = !req_valid_q || agu.req_ready;

    assign agu.req_valid   = req_valid_q;
    assign agu.req_base    = base_q[req_idx_q].value;
    assign agu.req_offset  = offset_q[req_idx_q];
    assign agu.req_payload = req_idx_q;
    assign agu.rsp_ready   = 1'b1;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_q      <= '0;
            tail_q      <= '0;
            requested_q <= '0;
            req_valid_q <= 1'b0;
            wr_valid_q  <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                entries_q[i].valid      <= 1'b0;
                entries_q[i].addr_valid <= 1'b0;
            end
        end else begin
            if (pick_load) begin
                req_valid_q <= pick_found;
                req_idx_q   <= pick_idx;
                if (pick_found) requested_q[pick_idx] <= 1'b1;
            end
            for (int i = 0; i < DEPTH; i++) begin
                entries_q[i].data <= lsu_pkg::capture_operand(entries_q[i].data, cdb);
                base_q[i]         <= lsu_pkg::capture_operand(base_q[i], cdb);
            end
            if (agu.rsp_valid) begin
                entries_q[agu.rsp_payload].addr       <= agu.rsp_addr;
                entries_q[agu.rsp_payload].addr_valid <= 1'b1;
            end
            if (alloc) begin
                entries_q[tail_q] <= '{valid: 1'b1, addr_valid: 1'b0, addr: '0,
                                       data: lsu_pkg::capture_operand(st_op.data, cdb)};
                base_q[tail_q]      <= lsu_pkg::capture_operand(st_op.base, cdb);
                offset_q[tail_q]    <= st_op.offset;
                requested_q[tail_q] <= 1'b0;
                tail_q              <= tail_q + 1'b1;
            end
            if (st_commit && head_ready) wr_valid_q <= 1'b1;
            if (wr_done) begin
                wr_valid_q                   <= 1'b0;
                entries_q[head_q].valid      <= 1'b0;
                entries_q[head_q].addr_valid <= 1'b0;
                head_q                       <= head_q + 1'b1;
            end
        end
    end

    assign mem_wr_valid = wr_valid_q;
    assign mem_wr_addr  = entries_q[head_q].addr;
    assign mem_wr_data  = entries_q[head_q].data.value;

    // Core commits only a complete head store with no write outstanding
    assert property (@(posedge clk) disable iff (rst || flush)
        st_commit |-> head_ready && !wr_valid_q);

endmodule

`default_nettype wire

// File: hw/load_rs.sv
`default_nettype none

`include "lsu_defines.svh"

module load_rs (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  lsu_pkg::cdb_packet_t cdb,
    input  logic                ld_valid,
    output logic                ld_ready,
    input  lsu_pkg::load_op_t   ld_op,
    input  lsu_pkg::stq_entry_t stq_entries [`LSU_STQ_DEPTH],
    input  lsu_pkg::stq_idx_t   stq_head,
    input  lsu_pkg::stq_mask_t  stq_occupied,
    agu_if.requester            agu,
    output logic                mem_rd_valid,
    input  logic                mem_rd_ready,
    output lsu_pkg::word_t      mem_rd_addr,
    input  logic                mem_rsp_valid,
    input  lsu_pkg::word_t      mem_rsp_data,
    output logic                wb_valid,
    input  logic                wb_ready,
    output lsu_pkg::tag_t       wb_tag,
    output lsu_pkg::word_t      wb_data,
    output logic                wb_forwarded
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_BASE,
        WAIT_AGU,
        RESOLVE,
        MEM_REQ,
        MEM_WAIT,
        WRITEBACK
    } state_t;

    state_t             state;
    lsu_pkg::load_op_t  op_q;
    lsu_pkg::stq_mask_t older_q;
    lsu_pkg::stq_mask_t older;
    lsu_pkg::word_t     addr_q;
    lsu_pkg::word_t     result_q;
    logic               fwd_q;

    logic              addr_unknown;
    logic              match;
    logic              match_ready;
    logic              resolve_go;
    lsu_pkg::stq_idx_t match_idx;
    lsu_pkg::stq_idx_t idx;

    // Older stores that have since retired drop out of the mask
    assign older = older_q & stq_occupied;

    // Scan from head toward tail so the last hit is the youngest older store
    always_comb begin
        addr_unknown = 1'b0;
        match        = 1'b0;
        match_idx    = '0;
        idx          = stq_head;
        for (int k = 0; k < `LSU_STQ_DEPTH; k++) begin
            if (older[idx]) begin
                if (!stq_entries[idx].addr_valid) begin
                    addr_unknown = 1'b1;
                end else if (stq_entries[idx].addr == addr_q) begin
                    match     = 1'b1;
                    match_idx = idx;
                end
            end
            idx = idx + 1'b1;
        end
        match_ready = match && stq_entries[match_idx].data.ready;
        resolve_go  = !addr_unknown && (!match || match_ready);
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (ld_valid) state <= WAIT_BASE;
                WAIT_BASE: if (agu.req_valid && agu.req_ready) state <= WAIT_AGU;
                WAIT_AGU:  if (agu.rsp_valid) state <= RESOLVE;
                RESOLVE:   if (resolve_go) state <= match ? WRITEBACK : MEM_REQ;
                MEM_REQ:   if (mem_rd_ready) state <= MEM_WAIT;
                MEM_WAIT:  if (mem_rsp_valid) state <= WRITEBACK;
                WRITEBACK: if (wb_ready) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid && ld_ready) begin
            op_q      <= ld_op;
            op_q.base <= lsu_pkg::capture_operand(ld_op.base, cdb);
            older_q   <= stq_occupied;
        end else begin
            op_q.base <= lsu_pkg::capture_operand(op_q.base, cdb);
            older_q   <= older;
        end
        if (state == WAIT_AGU && agu.rsp_valid) begin
            addr_q <= agu.rsp_addr;
        end
        if (state == RESOLVE && resolve_go && match) begin
            result_q <= stq_entries[match_idx].data.value;
            fwd_q    <= 1'b1;
        end
        if (state == MEM_WAIT && mem_rsp_valid) begin
            result_q <= mem_rsp_data;
            fwd_q    <= 1'b0;
        end
    end

    assign ld_ready = (state == IDLE);

    assign agu.req_valid   = (state == WAIT_BASE) && op_q.base.ready;
    assign agu.req_base    = op_q.base.value;
    assign agu.req_offset  = op_q.offset;
    assign agu.req_payload = op_q.dest;
    assign agu.rsp_ready   = (state == WAIT_AGU);

    assign mem_rd_valid = (state == MEM_REQ);
    assign mem_rd_addr  = addr_q;

    assign wb_valid     = (state == WRITEBACK);
    assign wb_tag       = op_q.dest;
    assign wb_data      = result_q;
    assign wb_forwarded = fwd_q;

    // Memory answers only a read this station is waiting for
    assert property (@(posedge clk) disable iff (rst || flush)
        mem_rsp_valid |-> state == MEM_WAIT);

    // Address from the AGU belongs to the load held here
    assert property (@(posedge clk) disable iff (rst || flush)
        agu.rsp_valid && agu.rsp_ready |-> agu.rsp_payload == op_q.dest);

endmodule

`default_nettype wire

// File: hw/agu.sv
`default_nettype none

module agu #(
    parameter type payload_t = lsu_pkg::tag_t
) (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    agu_if.agu   port
);

    logic           out_valid;
    lsu_pkg::word_t addr_q;
    payload_t       payload_q;
    logic           req_fire;

    // Accept when the output slot is free or drains this cycle
    assign port.req_ready = !out_valid || port.rsp_ready;
    assign req_fire = port.req_valid && port.req_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (req_fire) begin
            out_valid <= 1'b1;
        end else if (port.rsp_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q    <= port.req_base + port.req_offset;
            payload_q <= port.req_payload;
        end
    end

    assign port.rsp_valid   = out_valid;
    assign port.rsp_addr    = addr_q;
    assign port.rsp_payload = payload_q;

    // Stalled result stays put until the requester takes it
    assert property (@(posedge clk) disable iff (rst || flush)
        port.rsp_valid && !port.rsp_ready |=>
            port.rsp_valid && $stable(port.rsp_addr) && $stable(port.rsp_payload));

endmodule

`default_nettype wire

// File: common/agu_if.sv
`default_nettype none

interface agu_if #(
    parameter type payload_t = lsu_pkg::tag_t
);
    // Request channel
    logic           req_valid;
    logic           req_ready;
    lsu_pkg::word_t req_base;
    lsu_pkg::word_t req_offset;
    payload_t       req_payload;

    // Response channel
    logic           rsp_valid;
    logic           rsp_ready;
    lsu_pkg::word_t rsp_addr;
    payload_t       rsp_payload;

    modport requester (
        output req_valid, req_base, req_offset, req_payload, rsp_ready,
        input  req_ready, rsp_valid, rsp_addr, rsp_payload
    );

    modport agu (
        input  req_valid, req_base, req_offset, req_payload, rsp_ready,
        output req_ready, rsp_valid, rsp_addr, rsp_payload
    );

endinterface

`default_nettype wire

// File: common/lsu_pkg.sv
`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0] word_t;
    typedef logic [`LSU_TAG_W-1:0] tag_t;
    typedef logic [$clog2(`LSU_STQ_DEPTH)-1:0] stq_idx_t;
    typedef logic [`LSU_STQ_DEPTH-1:0] stq_mask_t;

    // Source operand waiting on a tag until ready
    typedef struct packed {
        tag_t  tag;
        logic  ready;
        word_t value;
    } operand_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } cdb_packet_t;

    typedef struct packed {
        tag_t     dest;
        operand_t base;
        word_t    offset;
    } load_op_t;

    typedef struct packed {
        operand_t base;
        operand_t data;
        word_t    offset;
    } store_op_t;

    // Store queue slot as seen by the load station
    typedef struct packed {
        logic     valid;
        logic     addr_valid;
        word_t    addr;
        operand_t data;
    } stq_entry_t;

    // Picks up a CDB broadcast for an operand still waiting on its tag
    function automatic operand_t capture_operand(operand_t op, cdb_packet_t cdb);
        operand_t res;
        res = op;
        if (!op.ready && cdb.valid && cdb.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = cdb.value;
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// File: common/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data and address width
`define LSU_XLEN 32

// Physical register tag width
`define LSU_TAG_W 6

// Store queue slots in a power of two so indices wrap by themselves
`define LSU_STQ_DEPTH 4

`endif
